//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_bt_bridge
FILELIST ?= all.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

SRCS := $(wildcard verilog/*.sv tb/*.sv)
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- all.f
verilog/bt_pkg.sv
verilog/sync_fifo.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/tx_sequencer.sv
verilog/rx_packet_sync.sv
verilog/bt_bridge.sv
tb/tb_bt_bridge.sv

//--- tb/tb_bt_bridge.sv
module tb_bt_bridge import bt_pkg::*; ();

	// 4 in-order, 40 burst, 4 hunting, 5 sync, 3 pass-through
	localparam int TOTAL_FRAMES = 56;
	localparam int TIMEOUT_CYCLES = TOTAL_FRAMES * 10 * CLKS_PER_BIT * 2 + 1000;
	localparam int BURST_LEN = 40;

	logic  clk;
	logic  rst_n;
	byte_t req_data_i;
	logic  req_valid_i;
	logic  req_ready_o;
	logic  rsp_rd_en_i;
	byte_t rsp_data_o;
	logic  rsp_valid_o;
	logic  rsp_empty_o;
	logic  bt_txd_i;
	logic  bt_rxd_o;

	byte_t exp_req [$];
	byte_t exp_rsp [$];
	int errors = 0;
	int cycles = 0;
	integer seed;

	bt_bridge u_bt_bridge (
		.clk         (clk),
		.rst_n       (rst_n),
		.req_data_i  (req_data_i),
		.req_valid_i (req_valid_i),
		.req_ready_o (req_ready_o),
		.rsp_rd_en_i (rsp_rd_en_i),
		.rsp_data_o  (rsp_data_o),
		.rsp_valid_o (rsp_valid_o),
		.rsp_empty_o (rsp_empty_o),
		.bt_txd_i    (bt_txd_i),
		.bt_rxd_o    (bt_rxd_o)
	);

	always #10 clk = ~clk;

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
			$display("errors: %0d", errors + 1);
			$display("Some tests failed");
			$finish;
		end
	end

	// a response byte only ever shows up one cycle after a read strobe
	a_rsp_valid_timing: assert property (@(posedge clk) disable iff (!rst_n)
		rsp_valid_o |-> $past(rsp_rd_en_i))
		else
		begin
			errors++;
			$display("rsp_valid_o rose with no read strobe the cycle before at %0t", $time);
		end

	a_outputs_known: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown(bt_rxd_o) && !$isunknown(req_ready_o) && !$isunknown(rsp_empty_o))
		else
		begin
			errors++;
			$display("an output of the bridge went unknown at %0t", $time);
		end

	task automatic compare_value(input string name, input byte_t expected, input byte_t actual);
		assert (actual === expected)
		else
		begin
			errors++;
			$display("Error at %0t: %s expected %02h, got %02h", $time, name, expected, actual);
		end
	endtask

	// 8N1 frame on the module's transmit line
	task automatic send_frame(input byte_t data);
		logic [9:0] bits;
		bits = {1'b1, data, 1'b0};
		for (int i = 0; i < 10; i++)
		begin
			@(posedge clk);
			#1;
			bt_txd_i = bits[i];
			repeat (CLKS_PER_BIT - 1) @(posedge clk);
		end
	endtask

	// samples at mid-bit, counted from the falling start edge
	task automatic capture_frame();
		byte_t data;
		byte_t expected;
		@(negedge bt_rxd_o);
		repeat (CLKS_PER_BIT / 2) @(negedge clk);
		compare_value("bt_rxd_o start bit", 8'h00, {7'b0, bt_rxd_o});
		for (int i = 0; i < 8; i++)
		begin
			repeat (CLKS_PER_BIT) @(negedge clk);
			data[i] = bt_rxd_o;
		end
		repeat (CLKS_PER_BIT) @(negedge clk);
		compare_value("bt_rxd_o stop bit", 8'h01, {7'b0, bt_rxd_o});
		assert (exp_req.size() != 0)
		else
		begin
			errors++;
			$display("frame %02h appeared on bt_rxd_o with no request byte pending", data);
		end
		if (exp_req.size() != 0)
		begin
			expected = exp_req.pop_front();
			compare_value("bt_rxd_o data", expected, data);
		end
	endtask

	// ready sampled at the falling edge holds through the next rising edge
	task automatic write_burst(input int count, output int accepted, output logic ready_fell);
		accepted = 0;
		ready_fell = 1'b0;
		for (int i = 0; i < count; i++)
		begin
			@(posedge clk);
			#1;
			req_valid_i = 1'b1;
			req_data_i = byte_t'($random(seed));
			@(negedge clk);
			if (req_ready_o)
			begin
				exp_req.push_back(req_data_i);
				accepted++;
			end
			else
				ready_fell = 1'b1;
		end
		@(posedge clk);
		#1;
		req_valid_i = 1'b0;
	endtask

	task automatic wait_request_drain();
		while (exp_req.size() != 0)
			@(posedge clk);
		// let the last stop bit finish so the sequencer is idle again
		repeat (CLKS_PER_BIT) @(posedge clk);
	endtask

	task automatic strobe_read();
		@(posedge clk);
		#1;
		rsp_rd_en_i = 1'b1;
		@(posedge clk);
		#1;
		rsp_rd_en_i = 1'b0;
		@(negedge clk);
	endtask

	task automatic read_response();
		byte_t expected;
		expected = exp_rsp.pop_front();
		@(negedge clk);
		compare_value("rsp_empty_o", 8'h00, {7'b0, rsp_empty_o});
		strobe_read();
		compare_value("rsp_valid_o", 8'h01, {7'b0, rsp_valid_o});
		compare_value("rsp_data_o", expected, rsp_data_o);
	endtask

	task automatic read_while_empty();
		@(negedge clk);
		compare_value("rsp_empty_o", 8'h01, {7'b0, rsp_empty_o});
		strobe_read();
		compare_value("rsp_valid_o", 8'h00, {7'b0, rsp_valid_o});
	endtask

	task automatic send_expected(input byte_t data);
		exp_rsp.push_back(data);
		send_frame(data);
	endtask

	initial
	begin
		wait (rst_n === 1'b1);
		forever
			capture_frame();
	end

	initial
	begin
		int accepted;
		logic ready_fell;
		byte_t hunt_bytes [4];
		clk = 1'b0;
		rst_n = 1'b0;
		req_data_i = '0;
		req_valid_i = 1'b0;
		rsp_rd_en_i = 1'b0;
		bt_txd_i = 1'b1;
		seed = 25;
		hunt_bytes = '{8'h12, 8'h55, 8'h34, 8'h50};
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// idle levels after reset
		@(negedge clk);
		compare_value("bt_rxd_o", 8'h01, {7'b0, bt_rxd_o});
		compare_value("req_ready_o", 8'h01, {7'b0, req_ready_o});
		compare_value("rsp_valid_o", 8'h00, {7'b0, rsp_valid_o});
		compare_value("rsp_empty_o", 8'h01, {7'b0, rsp_empty_o});

		write_burst(4, accepted, ready_fell);
		compare_value("accepted request bytes", 8'd4, byte_t'(accepted));
		wait_request_drain();

		// one byte already moved out to the serializer before the FIFO fills
		write_burst(BURST_LEN, accepted, ready_fell);
		assert (ready_fell)
		else
		begin
			errors++;
			$display("req_ready_o never fell during the %0d-byte burst", BURST_LEN);
		end
		compare_value("accepted burst bytes", byte_t'(FIFO_DEPTH + 1), byte_t'(accepted));
		wait_request_drain();

		// head and func separated, so no start pair
		foreach (hunt_bytes[i])
		begin
			send_frame(hunt_bytes[i]);
			@(negedge clk);
			compare_value("rsp_empty_o while hunting", 8'h01, {7'b0, rsp_empty_o});
		end
		read_while_empty();

		send_expected(PKT_HEAD);
		send_expected(PKT_FUNC);
		repeat (3)
			send_expected(byte_t'($random(seed)));
		while (exp_rsp.size() != 0)
			read_response();

		// a second pair is plain data once locked
		send_expected(PKT_HEAD);
		send_expected(PKT_FUNC);
		send_expected(byte_t'($random(seed)));
		while (exp_rsp.size() != 0)
			read_response();
		read_while_empty();

		$display("errors: %0d", errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

//--- verilog/bt_bridge.sv
module bt_bridge import bt_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  byte_t req_data_i,
	input  logic  req_valid_i,
	output logic  req_ready_o,
	input  logic  rsp_rd_en_i,
	output byte_t rsp_data_o,
	output logic  rsp_valid_o,
	output logic  rsp_empty_o,
	input  logic  bt_txd_i,
	output logic  bt_rxd_o
);

	// request path
	logic req_full;
	logic req_empty;
	logic req_rd_en;
	byte_t req_rd_data;
	logic req_rd_valid;
	logic tx_start;
	byte_t tx_data;
	logic tx_done;

	// response path
	logic rx_byte_valid;
	byte_t rx_byte;
	logic rsp_wr_valid;
	byte_t rsp_wr_data;

	assign req_ready_o = !req_full;

	sync_fifo u_req_fifo (
		.clk        (clk),
		.rst_n      (rst_n),
		.wr_valid_i (req_valid_i),
		.wr_data_i  (req_data_i),
		.full_o     (req_full),
		.rd_en_i    (req_rd_en),
		.rd_data_o  (req_rd_data),
		.rd_valid_o (req_rd_valid),
		.empty_o    (req_empty)
	);

	tx_sequencer u_tx_sequencer (
		.clk          (clk),
		.rst_n        (rst_n),
		.fifo_empty_i (req_empty),
		.fifo_rd_en_o (req_rd_en),
		.fifo_data_i  (req_rd_data),
		.fifo_valid_i (req_rd_valid),
		.tx_start_o   (tx_start),
		.tx_data_o    (tx_data),
		.tx_done_i    (tx_done)
	);

	uart_tx u_uart_tx (
		.clk     (clk),
		.rst_n   (rst_n),
		.start_i (tx_start),
		.data_i  (tx_data),
		.done_o  (tx_done),
		.line_o  (bt_rxd_o)
	);

	uart_rx u_uart_rx (
		.clk          (clk),
		.rst_n        (rst_n),
		.line_i       (bt_txd_i),
		.byte_valid_o (rx_byte_valid),
		.byte_o       (rx_byte)
	);

	rx_packet_sync u_rx_packet_sync (
		.clk          (clk),
		.rst_n        (rst_n),
		.byte_valid_i (rx_byte_valid),
		.byte_i       (rx_byte),
		.wr_valid_o   (rsp_wr_valid),
		.wr_data_o    (rsp_wr_data)
	);

	// full response FIFO silently drops incoming bytes
	sync_fifo u_rsp_fifo (
		.clk        (clk),
		.rst_n      (rst_n),
		.wr_valid_i (rsp_wr_valid),
		.wr_data_i  (rsp_wr_data),
		.full_o     (),
		.rd_en_i    (rsp_rd_en_i),
		.rd_data_o  (rsp_data_o),
		.rd_valid_o (rsp_valid_o),
		.empty_o    (rsp_empty_o)
	);

endmodule

//--- verilog/bt_pkg.sv
package bt_pkg;

	// serial link, fixed 8N1
	localparam int CLK_FREQ_HZ = 50_000_000;
	localparam int BAUD_RATE = 115_200;
	localparam int CLKS_PER_BIT = CLK_FREQ_HZ / BAUD_RATE;

	// both FIFOs share one size
	localparam int FIFO_ADDR_W = 5;
	localparam int FIFO_DEPTH = 2 ** FIFO_ADDR_W;

	typedef logic [7:0] byte_t;
	typedef logic [FIFO_ADDR_W-1:0] fifo_ptr_t;
	typedef logic [8:0] baud_cnt_t;

	// start pair that opens the response stream
	localparam byte_t PKT_HEAD = 8'h55;
	localparam byte_t PKT_FUNC = 8'h50;

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_FETCH,
		SEQ_SEND
	} tx_seq_state_e;

	typedef enum logic [1:0] {
		UART_IDLE,
		UART_START,
		UART_DATA,
		UART_STOP
	} uart_state_e;

	typedef enum logic [1:0] {
		SYNC_HUNT,
		SYNC_EMIT_FUNC,
		SYNC_PASS
	} sync_state_e;

endpackage

//--- verilog/rx_packet_sync.sv
module rx_packet_sync import bt_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  byte_valid_i,
	input  byte_t byte_i,
	output logic  wr_valid_o,
	output byte_t wr_data_o
);

	sync_state_e state;
	byte_t prev_q;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= SYNC_HUNT;
			prev_q <= '0;
			wr_valid_o <= 1'b0;
		end
		else
		begin
			wr_valid_o <= 1'b0;
			case (state)
				SYNC_HUNT:
				begin
					if (byte_valid_i)
					begin
						prev_q <= byte_i;
						if (prev_q == PKT_HEAD && byte_i == PKT_FUNC)
						begin
							// replay the pair, head first
							wr_valid_o <= 1'b1;
							wr_data_o <= PKT_HEAD;
							state <= SYNC_EMIT_FUNC;
						end
					end
				end
				SYNC_EMIT_FUNC:
				begin
					wr_valid_o <= 1'b1;
					wr_data_o <= PKT_FUNC;
					state <= SYNC_PASS;
				end
				SYNC_PASS:
				begin
					// locked until reset, later pairs are plain data
					wr_valid_o <= byte_valid_i;
					wr_data_o <= byte_i;
				end
				default:
					state <= SYNC_HUNT;
			endcase
		end
	end

endmodule

//--- verilog/sync_fifo.sv
module sync_fifo import bt_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  wr_valid_i,
	input  byte_t wr_data_i,
	output logic  full_o,
	input  logic  rd_en_i,
	output byte_t rd_data_o,
	output logic  rd_valid_o,
	output logic  empty_o
);

	byte_t mem [FIFO_DEPTH];
	fifo_ptr_t wr_ptr;
	fifo_ptr_t rd_ptr;
	logic [FIFO_ADDR_W:0] count;
	logic do_wr;
	logic do_rd;

	assign full_o = (count == (FIFO_ADDR_W + 1)'(FIFO_DEPTH));
	assign empty_o = (count == '0);

	// full blocks writes even when a read happens in the same cycle
	assign do_wr = wr_valid_i && !full_o;
	assign do_rd = rd_en_i && !empty_o;

	always_ff @(posedge clk)
	begin
		if (do_wr)
			mem[wr_ptr] <= wr_data_i;
		if (do_rd)
			rd_data_o <= mem[rd_ptr];
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			rd_valid_o <= 1'b0;
		end
		else
		begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			// pointers wrap naturally at the power-of-two depth
			if (do_wr && !do_rd)
				count <= count + 1'b1;
			else if (do_rd && !do_wr)
				count <= count - 1'b1;
			rd_valid_o <= do_rd;
		end
	end

	a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
		count <= (FIFO_ADDR_W + 1)'(FIFO_DEPTH))
		else $error("fifo occupancy exceeded its depth");

endmodule

//--- verilog/tx_sequencer.sv
module tx_sequencer import bt_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  fifo_empty_i,
	output logic  fifo_rd_en_o,
	input  byte_t fifo_data_i,
	input  logic  fifo_valid_i,
	output logic  tx_start_o,
	output byte_t tx_data_o,
	input  logic  tx_done_i
);

	tx_seq_state_e state;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= SEQ_IDLE;
			fifo_rd_en_o <= 1'b0;
			tx_start_o <= 1'b0;
		end
		else
		begin
			fifo_rd_en_o <= 1'b0;
			tx_start_o <= 1'b0;
			case (state)
				SEQ_IDLE:
				begin
					if (!fifo_empty_i)
					begin
						fifo_rd_en_o <= 1'b1;
						state <= SEQ_FETCH;
					end
				end
				SEQ_FETCH:
				begin
					// registered FIFO read lands one cycle after the enable
					if (fifo_valid_i)
					begin
						tx_start_o <= 1'b1;
						tx_data_o <= fifo_data_i;
						state <= SEQ_SEND;
					end
				end
				SEQ_SEND:
				begin
					if (tx_done_i)
						state <= SEQ_IDLE;
				end
				default:
					state <= SEQ_IDLE;
			endcase
		end
	end

	a_no_empty_read: assert property (@(posedge clk) disable iff (!rst_n)
		fifo_rd_en_o |-> !fifo_empty_i)
		else $error("request FIFO read while it was empty");

endmodule

//--- verilog/uart_rx.sv
module uart_rx import bt_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  line_i,
	output logic  byte_valid_o,
	output byte_t byte_o
);

	uart_state_e state;
	baud_cnt_t baud_cnt;
	logic [2:0] bit_idx;
	byte_t shift_q;
	logic rx_meta;
	logic rx_sync;
	logic rx_prev;
	logic bit_end;
	logic half_end;

	assign bit_end = (baud_cnt == baud_cnt_t'(CLKS_PER_BIT - 1));
	assign half_end = (baud_cnt == baud_cnt_t'(CLKS_PER_BIT / 2 - 1));
	assign byte_o = shift_q;

	// two-flop synchronizer, plus one more stage for edge detect
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end
		else
		begin
			rx_meta <= line_i;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= UART_IDLE;
			baud_cnt <= '0;
			bit_idx <= '0;
			byte_valid_o <= 1'b0;
		end
		else
		begin
			byte_valid_o <= 1'b0;
			baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
			case (state)
				UART_IDLE:
				begin
					baud_cnt <= '0;
					if (rx_prev && !rx_sync)
						state <= UART_START;
				end
				UART_START:
				begin
					// recheck at mid-bit, then count full bits from here
					if (half_end)
					begin
						baud_cnt <= '0;
						bit_idx <= '0;
						state <= rx_sync ? UART_IDLE : UART_DATA;
					end
				end
				UART_DATA:
				begin
					if (bit_end)
					begin
						shift_q <= {rx_sync, shift_q[7:1]};
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= UART_STOP;
					end
				end
				UART_STOP:
				begin
					if (bit_end)
					begin
						// low stop bit means a framing error, byte dropped
						byte_valid_o <= rx_sync;
						state <= UART_IDLE;
					end
				end
				default:
					state <= UART_IDLE;
			endcase
		end
	end

endmodule

//--- verilog/uart_tx.sv
module uart_tx import bt_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  start_i,
	input  byte_t data_i,
	output logic  done_o,
	output logic  line_o
);

	uart_state_e state;
	baud_cnt_t baud_cnt;
	logic [2:0] bit_idx;
	byte_t shift_q;
	logic bit_end;

	assign bit_end = (baud_cnt == baud_cnt_t'(CLKS_PER_BIT - 1));

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= UART_IDLE;
			baud_cnt <= '0;
			bit_idx <= '0;
			done_o <= 1'b0;
			line_o <= 1'b1;
		end
		else
		begin
			done_o <= 1'b0;
			baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
			case (state)
				UART_IDLE:
				begin
					baud_cnt <= '0;
					if (start_i)
					begin
						shift_q <= data_i;
						line_o <= 1'b0;
						state <= UART_START;
					end
				end
				UART_START:
				begin
					if (bit_end)
					begin
						line_o <= shift_q[0];
						shift_q <= shift_q >> 1;
						bit_idx <= '0;
						state <= UART_DATA;
					end
				end
				UART_DATA:
				begin
					if (bit_end)
					begin
						if (bit_idx == 3'd7)
						begin
							line_o <= 1'b1;
							state <= UART_STOP;
						end
						else
						begin
							line_o <= shift_q[0];
							shift_q <= shift_q >> 1;
							bit_idx <= bit_idx + 1'b1;
						end
					end
				end
				UART_STOP:
				begin
					if (bit_end)
					begin
						done_o <= 1'b1;
						state <= UART_IDLE;
					end
				end
				default:
					state <= UART_IDLE;
			endcase
		end
	end

	// the sequencer must wait for done before the next byte
	a_start_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
		start_i |-> state == UART_IDLE)
		else $error("uart_tx start strobe while a frame is in progress");

endmodule
